// File: Bender.yml
package:
  name: conv_engine

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/conv_geom_pkg.sv
      - verilog/conv_data_pkg.sv
      - verilog/scan_if.sv
      - verilog/frame_scan_ctrl.sv
      - verilog/ifm_row_buffer.sv
      - verilog/filter_buffer.sv
      - verilog/conv_mac_array.sv
      - verilog/conv_engine_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_clock.sv
      - tests/conv_engine_tb.sv

// File: sim.f
+incdir+verilog
verilog/conv_geom_pkg.sv
verilog/conv_data_pkg.sv
verilog/scan_if.sv
verilog/frame_scan_ctrl.sv
verilog/ifm_row_buffer.sv
verilog/filter_buffer.sv
verilog/conv_mac_array.sv
verilog/conv_engine_top.sv
tests/tb_clock.sv
tests/conv_engine_tb.sv

// File: tests/conv_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_engine_tb
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
();

    localparam int MAX_RES = `CONV_ROWS * `CONV_MAX_COL;
    localparam int N_ADDR  = `CONV_MAX_TILES * `CONV_LANES;

    logic      clk;
    logic      rstn;
    logic      start;
    col_t      width;
    tile_t     tiles;
    logic      ifm_we;
    row_t      ifm_row;
    col_t      ifm_col;
    tile_t     ifm_tile;
    ifm_word_u ifm_wdata;
    logic      flt_we;
    och_t      flt_och;
    flt_addr_t flt_addr;
    kernel_t   flt_wdata;
    logic      busy;
    logic      psum_valid;
    psum_vec_t psum;
    logic      done;

    // shadow copies of both memories
    ifm_word_u   pix_sh [`CONV_ROWS][`CONV_MAX_COL][`CONV_MAX_TILES];
    kernel_t     flt_sh [`CONV_N_OCH][N_ADDR];
    // expected results in row-major order
    psum_t       exp_psum [MAX_RES][`CONV_N_OCH];
    int unsigned seed_val;

    tb_clock #(.PERIOD_NS(40.0)) u_clk (.clk(clk));

    conv_engine_top dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_start      (start),
        .i_width      (width),
        .i_tiles      (tiles),
        .i_ifm_we     (ifm_we),
        .i_ifm_row    (ifm_row),
        .i_ifm_col    (ifm_col),
        .i_ifm_tile   (ifm_tile),
        .i_ifm_wdata  (ifm_wdata.raw),
        .i_flt_we     (flt_we),
        .i_flt_och    (flt_och),
        .i_flt_addr   (flt_addr),
        .i_flt_wdata  (flt_wdata),
        .o_busy       (busy),
        .o_psum_valid (psum_valid),
        .o_psum       (psum),
        .o_done       (done)
    );

    // ------------------------------------------------------------------------
    // error exits and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic timeout_stop(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        stop_run();
    endtask

    task automatic check_psum(input psum_t actual, input psum_t expected,
                              input int och, input int idx);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: o_psum[%0d] result %0d expected %0d actual %0d",
                     $time, och, idx, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string name);
        if (actual != expected) begin
            $display("FAILED at %0t ns: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %b actual %b",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // data setup
    // ------------------------------------------------------------------------
    task automatic fill_random();
        for (int r = 0; r < `CONV_ROWS; r++)
            for (int c = 0; c < `CONV_MAX_COL; c++)
                for (int t = 0; t < `CONV_MAX_TILES; t++)
                    pix_sh[r][c][t].raw = $urandom;
        for (int o = 0; o < `CONV_N_OCH; o++)
            for (int a = 0; a < N_ADDR; a++)
                for (int k = 0; k < `CONV_K * `CONV_K; k++)
                    flt_sh[o][a][k] = weight_t'($urandom);
    endtask

    // distinct pixels and a single corner tap per channel
    // channel o reads lane o of tile 0
    task automatic fill_corner();
        int tap;
        for (int r = 0; r < `CONV_ROWS; r++)
            for (int c = 0; c < `CONV_MAX_COL; c++)
                for (int t = 0; t < `CONV_MAX_TILES; t++)
                    for (int l = 0; l < `CONV_LANES; l++)
                        pix_sh[r][c][t].lane[l] =
                            pixel_t'(1 + t * 128 + r * 64 + c * 4 + l);
        for (int o = 0; o < `CONV_N_OCH; o++) begin
            for (int a = 0; a < N_ADDR; a++)
                flt_sh[o][a] = '0;
            // och 0 to 3 take top-left, top-right, bottom-left and bottom-right
            tap = ((o < 2) ? 0 : 6) + ((o % 2 == 1) ? 2 : 0);
            flt_sh[o][o][tap] = 8'sd1;
        end
    endtask

    // push both shadows into the DUT one word per clock
    task automatic load_memories();
        for (int r = 0; r < `CONV_ROWS; r++)
            for (int c = 0; c < `CONV_MAX_COL; c++)
                for (int t = 0; t < `CONV_MAX_TILES; t++) begin
                    ifm_we    = 1'b1;
                    ifm_row   = row_t'(r);
                    ifm_col   = col_t'(c);
                    ifm_tile  = tile_t'(t);
                    ifm_wdata = pix_sh[r][c][t];
                    @(negedge clk);
                end
        ifm_we = 1'b0;
        for (int o = 0; o < `CONV_N_OCH; o++)
            for (int a = 0; a < N_ADDR; a++) begin
                flt_we    = 1'b1;
                flt_och   = och_t'(o);
                flt_addr  = flt_addr_t'(a);
                flt_wdata = flt_sh[o][a];
                @(negedge clk);
            end
        flt_we = 1'b0;
    endtask

    // sum of pixel * weight over tiles, lanes and taps
    // pixels outside the band or the width count as zero
    task automatic compute_model(input int w, input int nt);
        int acc;
        int rr;
        int cc;
        for (int r = 0; r < `CONV_ROWS; r++)
            for (int c = 0; c < w; c++)
                for (int o = 0; o < `CONV_N_OCH; o++) begin
                    acc = 0;
                    for (int t = 0; t < nt; t++)
                        for (int l = 0; l < `CONV_LANES; l++)
                            for (int k = 0; k < `CONV_K * `CONV_K; k++) begin
                                rr = r + k / `CONV_K - 1;
                                cc = c + k % `CONV_K - 1;
                                if (rr >= 0 && rr < `CONV_ROWS && cc >= 0 && cc < w)
                                    acc += int'(pix_sh[rr][cc][t].lane[l]) *
                                           int'(flt_sh[o][t * `CONV_LANES + l][k]);
                            end
                    exp_psum[r * w + c][o] = psum_t'(acc);
                end
    endtask

    // ------------------------------------------------------------------------
    // start one frame and compare its results in row-major order
    // ------------------------------------------------------------------------
    task automatic run_frame(input int w, input int nt, input bit poke_start);
        int total;
        int n_res;
        int cyc;
        int done_at;
        int limit;
        total   = `CONV_ROWS * w;
        n_res   = 0;
        cyc     = 0;
        done_at = -1;
        limit   = `CONV_ROWS * w * nt + 16;
        width   = col_t'(w);
        tiles   = tile_t'(nt);
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag(busy, 1'b1, "o_busy after start");
        while (busy) begin
            if (cyc > limit)
                timeout_stop("end of frame");
            if (psum_valid) begin
                check_flag(done, (n_res == total - 1), "o_done");
                if (n_res < total)
                    for (int o = 0; o < `CONV_N_OCH; o++)
                        check_psum(psum[o], exp_psum[n_res][o], o, n_res);
                n_res++;
            end else begin
                check_flag(done, 1'b0, "o_done without o_psum_valid");
            end
            if (done)
                done_at = cyc;
            // extra start in mid-frame that the DUT must ignore
            start = (poke_start && cyc == w) ? 1'b1 : 1'b0;
            @(negedge clk);
            cyc++;
        end
        check_count(n_res, total, "result count");
        check_count(cyc - done_at, 1, "cycles from o_done to o_busy low");
        check_flag(psum_valid, 1'b0, "o_psum_valid after frame");
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic idle_after_reset();
        repeat (10) begin
            check_flag(busy, 1'b0, "o_busy while idle");
            check_flag(psum_valid, 1'b0, "o_psum_valid while idle");
            check_flag(done, 1'b0, "o_done while idle");
            @(negedge clk);
        end
    endtask

    task automatic full_frame();
        fill_random();
        load_memories();
        compute_model(16, 2);
        run_frame(16, 2, 1'b0);
    endtask

    // expected values straight from the corner positions
    task automatic padding_edges();
        int rr;
        int cc;
        fill_corner();
        load_memories();
        for (int r = 0; r < `CONV_ROWS; r++)
            for (int c = 0; c < 5; c++)
                for (int o = 0; o < `CONV_N_OCH; o++) begin
                    rr = r + ((o < 2) ? -1 : 1);
                    cc = c + ((o % 2 == 0) ? -1 : 1);
                    if (rr >= 0 && rr < `CONV_ROWS && cc >= 0 && cc < 5)
                        exp_psum[r * 5 + c][o] = psum_t'(pix_sh[rr][cc][0].lane[o]);
                    else
                        exp_psum[r * 5 + c][o] = '0;
                end
        run_frame(5, 1, 1'b0);
    endtask

    task automatic narrow_frame();
        fill_random();
        load_memories();
        compute_model(4, 1);
        run_frame(4, 1, 1'b0);
    endtask

    task automatic start_while_busy();
        fill_random();
        load_memories();
        compute_model(6, 2);
        run_frame(6, 2, 1'b1);
        // no second frame may follow
        repeat (8) begin
            check_flag(busy, 1'b0, "o_busy after ignored start");
            check_flag(psum_valid, 1'b0, "o_psum_valid after ignored start");
            @(negedge clk);
        end
    endtask

    task automatic back_to_back_frames();
        fill_random();
        load_memories();
        compute_model(8, 2);
        run_frame(8, 2, 1'b0);
        fill_random();
        load_memories();
        compute_model(7, 2);
        run_frame(7, 2, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed_val  = $urandom(32'he8b2);
        rstn      = 1'b0;
        start     = 1'b0;
        width     = '0;
        tiles     = '0;
        ifm_we    = 1'b0;
        ifm_row   = '0;
        ifm_col   = '0;
        ifm_tile  = '0;
        ifm_wdata = '0;
        flt_we    = 1'b0;
        flt_och   = '0;
        flt_addr  = '0;
        flt_wdata = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        idle_after_reset();
        full_frame();
        padding_edges();
        narrow_frame();
        start_while_busy();
        back_to_back_frames();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock
module tb_clock #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verilog/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// ---------------------------------------------------------------------------
// datapath sizing
// ---------------------------------------------------------------------------
// input channels packed into one ifm word
`define CONV_LANES      4
`define CONV_PIX_W      8
`define CONV_WGT_W      8
`define CONV_PSUM_W     32

// ---------------------------------------------------------------------------
// geometry
// ---------------------------------------------------------------------------
// square kernel edge
`define CONV_K          3
// band height, fixed
`define CONV_ROWS       3
`define CONV_MAX_COL    16
`define CONV_MAX_TILES  2
`define CONV_N_OCH      4

`endif

// File: verilog/conv_data_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_data_pkg;

    typedef logic [`CONV_PIX_W-1:0] pixel_t;
    typedef logic signed [`CONV_WGT_W-1:0] weight_t;

    // host view is the raw word, mac view is per-lane pixels
    // lane 0 in the low byte
    typedef union packed {
        logic [`CONV_LANES*`CONV_PIX_W-1:0] raw;
        pixel_t [`CONV_LANES-1:0] lane;
    } ifm_word_u;

    // tap 0 = top-left, row-major, tap 0 in the top byte
    typedef weight_t [0:`CONV_K*`CONV_K-1] kernel_t;

    // [row][col] of the 3x3 neighbourhood
    typedef ifm_word_u [0:`CONV_K-1][0:`CONV_K-1] window_t;

    typedef logic signed [`CONV_PSUM_W-1:0] psum_t;
    // one partial sum per output channel
    typedef psum_t [`CONV_N_OCH-1:0] psum_vec_t;
    // one kernel per input lane
    typedef kernel_t [`CONV_LANES-1:0] lane_kernels_t;

endpackage

`default_nettype wire

// File: verilog/conv_engine_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_engine_top
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_start,
    input  col_t                               i_width,
    input  tile_t                              i_tiles,
    input  logic                               i_ifm_we,
    input  row_t                               i_ifm_row,
    input  col_t                               i_ifm_col,
    input  tile_t                              i_ifm_tile,
    input  logic [`CONV_LANES*`CONV_PIX_W-1:0] i_ifm_wdata,
    input  logic                               i_flt_we,
    input  och_t                               i_flt_och,
    input  flt_addr_t                          i_flt_addr,
    input  kernel_t                            i_flt_wdata,
    output logic                               o_busy,
    output logic                               o_psum_valid,
    output psum_vec_t                          o_psum,
    output logic                               o_done
);

    window_t                         window;
    lane_kernels_t [`CONV_N_OCH-1:0] kernels;
    logic                            rd_beat;
    logic                            rd_last_tile;
    logic                            rd_last_beat;

    scan_if u_scan ();

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    frame_scan_ctrl u_ctrl (
        .clk     (clk),
        .rstn    (rstn),
        .i_start (i_start),
        .i_width (i_width),
        .i_tiles (i_tiles),
        .o_busy  (o_busy),
        .scan    (u_scan.source)
    );

    // ------------------------------------------------------------------------
    // buffers, one cycle read
    // ------------------------------------------------------------------------
    ifm_row_buffer u_ifm (
        .clk         (clk),
        .rstn        (rstn),
        .i_we        (i_ifm_we),
        .i_wrow      (i_ifm_row),
        .i_waddr     ({i_ifm_col, i_ifm_tile}),
        .i_wdata     (i_ifm_wdata),
        .scan        (u_scan.sink),
        .o_window    (window),
        .o_beat      (rd_beat),
        .o_last_tile (rd_last_tile),
        .o_last_beat (rd_last_beat)
    );

    filter_buffer u_flt (
        .clk       (clk),
        .rstn      (rstn),
        .i_we      (i_flt_we),
        .i_och     (i_flt_och),
        .i_waddr   (i_flt_addr),
        .i_wdata   (i_flt_wdata),
        .scan      (u_scan.sink),
        .o_kernels (kernels)
    );

    // mac, partial sums out
    conv_mac_array u_mac (
        .clk          (clk),
        .rstn         (rstn),
        .i_window     (window),
        .i_kernels    (kernels),
        .i_beat       (rd_beat),
        .i_last_tile  (rd_last_tile),
        .i_last_beat  (rd_last_beat),
        .o_psum       (o_psum),
        .o_psum_valid (o_psum_valid),
        .o_done       (o_done)
    );

endmodule

`default_nettype wire

// File: verilog/conv_geom_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_geom_pkg;

    // row inside the band
    typedef logic [$clog2(`CONV_ROWS)-1:0] row_t;

    // column index, wide enough to hold the width itself
    typedef logic [$clog2(`CONV_MAX_COL+1)-1:0] col_t;

    // tile index, also used for the tile count
    typedef logic [$clog2(`CONV_MAX_TILES+1)-1:0] tile_t;

    // filter word address, tile * lanes + lane
    typedef logic [$clog2(`CONV_MAX_TILES*`CONV_LANES)-1:0] flt_addr_t;

    typedef logic [$clog2(`CONV_N_OCH)-1:0] och_t;

endpackage

`default_nettype wire

// File: verilog/conv_mac_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_mac_array
    import conv_data_pkg::*;
(
    input  logic                            clk,
    input  logic                            rstn,
    input  window_t                         i_window,
    input  lane_kernels_t [`CONV_N_OCH-1:0] i_kernels,
    input  logic                            i_beat,
    input  logic                            i_last_tile,
    input  logic                            i_last_beat,
    output psum_vec_t                       o_psum,
    output logic                            o_psum_valid,
    output logic                            o_done
);

    localparam int K = `CONV_K;

    psum_vec_t tile_sum;
    psum_vec_t acc_d;
    psum_vec_t acc_q;
    psum_vec_t res_q;
    // next beat starts a new pixel
    logic      fresh_q;
    logic      res_vld_q;
    logic      res_last_q;

    // ------------------------------------------------------------------------
    // dot product of one tile, 9 taps x 4 lanes per channel
    // ------------------------------------------------------------------------
    always_comb begin
        psum_t   prod;
        pixel_t  px;
        weight_t wt;
        for (int o = 0; o < `CONV_N_OCH; o++) begin
            tile_sum[o] = '0;
            for (int l = 0; l < `CONV_LANES; l++) begin
                for (int t = 0; t < K * K; t++) begin
                    px = i_window[t / K][t % K].lane[l];
                    wt = i_kernels[o][l][t];
                    // unsigned pixel times signed weight
                    prod = $signed({1'b0, px}) * wt;
                    tile_sum[o] = tile_sum[o] + prod;
                end
            end
        end
    end

    // restart from zero on the first tile of a pixel
    always_comb begin
        for (int o = 0; o < `CONV_N_OCH; o++) begin
            acc_d[o] = (fresh_q ? psum_t'(0) : acc_q[o]) + tile_sum[o];
        end
    end

    // ------------------------------------------------------------------------
    // accumulator, result stage, output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_beat) begin
            acc_q <= acc_d;
        end
        if (i_beat && i_last_tile) begin
            res_q <= acc_d;
        end
        // output holds while the next pixel accumulates
        if (res_vld_q) begin
            o_psum <= res_q;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fresh_q      <= 1'b1;
            res_vld_q    <= 1'b0;
            res_last_q   <= 1'b0;
            o_psum_valid <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            if (i_beat) begin
                fresh_q <= i_last_tile;
            end
            res_vld_q    <= i_beat && i_last_tile;
            res_last_q   <= i_beat && i_last_beat;
            o_psum_valid <= res_vld_q;
            // done lines up with the final valid
            o_done       <= res_last_q;
        end
    end

endmodule

`default_nettype wire

// File: verilog/filter_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module filter_buffer
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_we,
    input  och_t                               i_och,
    input  flt_addr_t                          i_waddr,
    input  kernel_t                            i_wdata,
    scan_if.sink                               scan,
    output lane_kernels_t [`CONV_N_OCH-1:0]    o_kernels
);

    // per output channel, tiles x lanes kernels
    kernel_t mem [`CONV_N_OCH][`CONV_MAX_TILES*`CONV_LANES];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_och][i_waddr] <= i_wdata;
        end
    end

    // all lane kernels of the current tile, every channel at once
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_kernels <= '0;
        end else if (scan.beat) begin
            for (int o = 0; o < `CONV_N_OCH; o++) begin
                for (int l = 0; l < `CONV_LANES; l++) begin
                    o_kernels[o][l] <= mem[o][flt_addr_t'(int'(scan.tile) * `CONV_LANES + l)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/frame_scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module frame_scan_ctrl
    import conv_geom_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   i_start,
    input  col_t   i_width,
    input  tile_t  i_tiles,
    output logic   o_busy,
    scan_if.source scan
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SCAN  = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;
    // buffer read + result stage + output stage
    localparam int DRAIN_CYC = 3;

    logic [1:0] state;
    logic [1:0] drain_cnt;
    col_t       width_q;
    tile_t      tiles_q;
    row_t       row_q;
    col_t       col_q;
    tile_t      tile_q;
    logic       at_last_tile;
    logic       at_last_col;
    logic       at_last_beat;

    // ------------------------------------------------------------------------
    // position flags
    // ------------------------------------------------------------------------
    assign at_last_tile = (tile_q == tiles_q - tile_t'(1));
    assign at_last_col  = (col_q == width_q - col_t'(1));
    // last tile of the last column of the bottom row
    assign at_last_beat = at_last_tile && at_last_col && (row_q == row_t'(`CONV_ROWS - 1));

    assign scan.beat      = (state == ST_SCAN);
    assign scan.row       = row_q;
    assign scan.col       = col_q;
    assign scan.tile      = tile_q;
    assign scan.first_col = (col_q == '0);
    assign scan.last_col  = at_last_col;
    assign scan.last_tile = at_last_tile;
    assign scan.last_beat = at_last_beat;

    // busy covers the pipeline drain too
    assign o_busy = (state != ST_IDLE);

    // ------------------------------------------------------------------------
    // fsm and nested counters, tile fastest
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            drain_cnt <= '0;
            width_q   <= '0;
            tiles_q   <= '0;
            row_q     <= '0;
            col_q     <= '0;
            tile_q    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // start only seen here, ignored while busy
                    if (i_start) begin
                        state   <= ST_SCAN;
                        width_q <= i_width;
                        tiles_q <= i_tiles;
                        row_q   <= '0;
                        col_q   <= '0;
                        tile_q  <= '0;
                    end
                end
                ST_SCAN: begin
                    if (at_last_tile) begin
                        tile_q <= '0;
                        if (at_last_col) begin
                            col_q <= '0;
                            row_q <= row_q + row_t'(1);
                        end else begin
                            col_q <= col_q + col_t'(1);
                        end
                    end else begin
                        tile_q <= tile_q + tile_t'(1);
                    end
                    if (at_last_beat) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                ST_DRAIN: begin
                    // wait for the final result to leave
                    if (drain_cnt == 2'(DRAIN_CYC - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/ifm_row_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module ifm_row_buffer
    import conv_geom_pkg::*;
    import conv_data_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_we,
    input  row_t                                  i_wrow,
    input  logic [$bits(col_t)+$bits(tile_t)-1:0] i_waddr,
    input  ifm_word_u                             i_wdata,
    scan_if.sink                                  scan,
    output window_t                               o_window,
    output logic                                  o_beat,
    output logic                                  o_last_tile,
    output logic                                  o_last_beat
);

    localparam int K       = `CONV_K;
    localparam int COL_AW  = $clog2(`CONV_MAX_COL);
    localparam int TILE_AW = $clog2(`CONV_MAX_TILES);
    localparam int TILE_W  = $bits(tile_t);

    // three rows of width x tiles words
    ifm_word_u mem [`CONV_ROWS][`CONV_MAX_COL][`CONV_MAX_TILES];
    col_t      wcol;
    tile_t     wtile;
    window_t   win_d;

    // host address is {col, tile}
    assign wcol  = i_waddr[$bits(i_waddr)-1:TILE_W];
    assign wtile = i_waddr[TILE_W-1:0];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wrow][wcol[COL_AW-1:0]][wtile[TILE_AW-1:0]] <= i_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // padded 3x3 gather around (row, col) for the current tile
    // ------------------------------------------------------------------------
    always_comb begin
        row_t r_src;
        int   c_src;
        logic in_band;
        for (int dr = 0; dr < K; dr++) begin
            for (int dc = 0; dc < K; dc++) begin
                r_src   = row_t'(int'(scan.row) + dr - 1);
                c_src   = int'(scan.col) + dc - 1;
                // top/bottom of band, left/right of frame
                in_band = !((dr == 0) && (scan.row == '0)) &&
                          !((dr == K - 1) && (scan.row == row_t'(`CONV_ROWS - 1))) &&
                          !((dc == 0) && scan.first_col) &&
                          !((dc == K - 1) && scan.last_col);
                if (in_band) begin
                    win_d[dr][dc] = mem[r_src][c_src[COL_AW-1:0]][scan.tile[TILE_AW-1:0]];
                end else begin
                    win_d[dr][dc].raw = '0;
                end
            end
        end
    end

    // window register, loads only on a beat
    always_ff @(posedge clk) begin
        if (scan.beat) begin
            o_window <= win_d;
        end
    end

    // flags follow the window by one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_beat      <= 1'b0;
            o_last_tile <= 1'b0;
            o_last_beat <= 1'b0;
        end else begin
            o_beat      <= scan.beat;
            o_last_tile <= scan.beat && scan.last_tile;
            o_last_beat <= scan.beat && scan.last_beat;
        end
    end

endmodule

`default_nettype wire

// File: verilog/scan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface scan_if
    import conv_geom_pkg::*;
();

    // one scan position per beat
    logic  beat;
    row_t  row;
    col_t  col;
    tile_t tile;
    // padding edges
    logic  first_col;
    logic  last_col;
    // end of pixel accumulation / end of frame
    logic  last_tile;
    logic  last_beat;

    modport source (
        output beat, row, col, tile, first_col, last_col, last_tile, last_beat
    );

    modport sink (
        input beat, row, col, tile, first_col, last_col, last_tile, last_beat
    );

endinterface

`default_nettype wire
